/* src/cfg_ram_cfg.svh */
`ifndef CFG_RAM_CFG_SVH
`define CFG_RAM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Table geometry
//////////////////////////////////////////////////////////////////////

// Address width, 32 entries
`define CFG_ADDR_BITS 5

// Word width of one table entry
`define CFG_DATA_WIDTH 32

// Parity protection, one extra bit per stored word
// Set to 0 to store and check a constant zero instead
`define CFG_RAM_PARITY 1

`endif

/* src/cfg_ram_pkg.sv */
`default_nettype none

`include "cfg_ram_cfg.svh"

package cfg_ram_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////////////////////////

    // CPU request, top address bit selects the register space
    typedef struct packed {
        logic                           en;
        logic                           ws;
        logic                           rs;
        logic [`CFG_ADDR_BITS:0]        addr;
        logic [`CFG_DATA_WIDTH-1:0]     wdata;
    } cpu_req_t;

    // CPU response, rdy is a single-cycle pulse
    typedef struct packed {
        logic                           rdy;
        logic [`CFG_DATA_WIDTH-1:0]     rdata;
    } cpu_rsp_t;

    // Engine read port
    typedef struct packed {
        logic                           re;
        logic [`CFG_ADDR_BITS-1:0]      addr;
    } eng_req_t;

    // Static parity controls from the register block
    typedef struct packed {
        logic                           force_err;
        logic                           err_dis;
    } par_ctrl_t;

    // Pending CPU read
    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_WAIT = 1'b1
    } cpu_rd_state_e;

    // Register offsets inside the register space
    typedef enum logic [`CFG_ADDR_BITS-1:0] {
        REG_PAR_CTRL = `CFG_ADDR_BITS'd0,
        REG_PAR_STAT = `CFG_ADDR_BITS'd1
    } reg_off_e;

endpackage

`default_nettype wire

/* src/cfg_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ram_cfg.svh"

module cfg_sram
(
    input  logic                            clk,
    // Write port
    input  logic                            we,
    input  logic [`CFG_ADDR_BITS-1:0]       wa,
    input  logic [`CFG_DATA_WIDTH:0]        wd,
    // Read port
    input  logic                            re,
    input  logic [`CFG_ADDR_BITS-1:0]       ra,
    output logic [`CFG_DATA_WIDTH:0]        rd
);

    localparam int AW    = `CFG_ADDR_BITS;
    localparam int DEPTH = 1 << AW;

    // Data plus parity bit per entry
    logic [`CFG_DATA_WIDTH:0]   mem [DEPTH];

    logic [AW-1:0]              ra_q;
    logic                       re_q;

    // Write lands at the clock edge
    always_ff @(posedge clk)
    begin
        if (we)
            mem[wa] <= wd;
    end

    // First read stage, address register
    always_ff @(posedge clk)
    begin
        re_q <= re;
        if (re)
            ra_q <= ra;
    end

    // Second read stage, output register holds when idle
    always_ff @(posedge clk)
    begin
        if (re_q)
            rd <= mem[ra_q];
    end

endmodule

`default_nettype wire

/* src/cfg_ram_par.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ram_cfg.svh"

module cfg_ram_par
(
    input  logic                            clk,
    input  logic                            rst,
    // Engine read side
    input  cfg_ram_pkg::eng_req_t           eng_req,
    input  logic                            active,
    output logic [`CFG_DATA_WIDTH-1:0]      eng_rdata,
    // CPU side, already decoded to the RAM space
    input  cfg_ram_pkg::cpu_req_t           cpu_req,
    output cfg_ram_pkg::cpu_rsp_t           cpu_rsp,
    // Parity controls and error pulse
    input  cfg_ram_pkg::par_ctrl_t          par_ctrl,
    output logic                            par_err
);

    import cfg_ram_pkg::*;

    localparam int AW     = `CFG_ADDR_BITS;
    localparam int DW     = `CFG_DATA_WIDTH;
    localparam bit PAR_EN = `CFG_RAM_PARITY;

    //////////////////////////////////////////////////////////////////////
    // Request qualification
    //////////////////////////////////////////////////////////////////////

    logic               eng_rd;
    logic               cpu_wr;
    logic               cpu_rd;
    logic [AW-1:0]      cpu_addr;

    // Engine reads only count while active
    assign eng_rd   = eng_req.re & active;
    assign cpu_wr   = cpu_req.en & cpu_req.ws;
    assign cpu_rd   = cpu_req.en & cpu_req.rs;
    assign cpu_addr = cpu_req.addr[AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // Write pipeline
    //////////////////////////////////////////////////////////////////////

    logic [1:0]         wr_sr;
    logic               par_q;
    logic               mem_we;
    logic [DW:0]        mem_wd;

    // Strobe delayed two cycles, addr and wdata held by the master
    always_ff @(posedge clk)
    begin
        if (rst)
            wr_sr <= '0;
        else
            wr_sr <= {wr_sr[0], cpu_wr};
    end

    // Parity built in the cycle after the strobe
    // force_err flips the stored bit to plant an error
    always_ff @(posedge clk)
    begin
        par_q <= PAR_EN & ((^cpu_req.wdata) ^ par_ctrl.force_err);
    end

    assign mem_we = wr_sr[1];
    assign mem_wd = {par_q, cpu_req.wdata};

    //////////////////////////////////////////////////////////////////////
    // Pending CPU read and array read port
    //////////////////////////////////////////////////////////////////////

    cpu_rd_state_e      rd_state;
    logic               rd_pend;
    logic               cpu_launch;
    logic               arr_re;
    logic [AW-1:0]      arr_ra;
    logic               wr_hit;
    logic [DW:0]        arr_rd;

    assign rd_pend = (rd_state == RD_WAIT);

    // Launch once the engine is idle or reads the same word
    assign cpu_launch = rd_pend & (~eng_rd | (eng_req.addr == cpu_addr));

    always_ff @(posedge clk)
    begin
        if (rst)
            rd_state <= RD_IDLE;
        else if (!cpu_req.en)
            // Access dropped, forget the pending read
            rd_state <= RD_IDLE;
        else
        begin
            case (rd_state)
                RD_IDLE:
                    if (cpu_rd)
                        rd_state <= RD_WAIT;
                RD_WAIT:
                    if (cpu_launch)
                        rd_state <= RD_IDLE;
                default:
                    rd_state <= RD_IDLE;
            endcase
        end
    end

    // Engine owns the address whenever it reads
    assign arr_ra = eng_rd ? eng_req.addr : cpu_addr;

    // Same-cycle write to the read address kills the read
    assign wr_hit = mem_we & (cpu_addr == arr_ra);
    assign arr_re = (eng_rd | rd_pend) & ~wr_hit;

    cfg_sram u_sram
    (
        .clk    (clk),
        .we     (mem_we),
        .wa     (cpu_addr),
        .wd     (mem_wd),
        .re     (arr_re),
        .ra     (arr_ra),
        .rd     (arr_rd)
    );

    // Engine data straight off the array output register
    assign eng_rdata = arr_rd[DW-1:0];

    //////////////////////////////////////////////////////////////////////
    // CPU ready and read data
    //////////////////////////////////////////////////////////////////////

    logic [3:0]         rdy_sr;
    logic [2:0]         crd_sr;
    logic [DW:0]        rd_q;
    logic [DW-1:0]      cpu_rdata_q;

    // Writes enter one cycle after strobe, reads at launch
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rdy_sr <= '0;
            crd_sr <= '0;
        end
        else
        begin
            rdy_sr <= {rdy_sr[2:0], cpu_launch | wr_sr[0]};
            crd_sr <= {crd_sr[1:0], cpu_launch};
        end
    end

    // Array output registered once more, shared by CPU and checker
    always_ff @(posedge clk)
    begin
        rd_q <= arr_rd;
    end

    // Capture the CPU word three cycles after launch
    always_ff @(posedge clk)
    begin
        if (crd_sr[2])
            cpu_rdata_q <= rd_q[DW-1:0];
    end

    assign cpu_rsp.rdy   = rdy_sr[3];
    assign cpu_rsp.rdata = cpu_req.en ? cpu_rdata_q : '0;

    //////////////////////////////////////////////////////////////////////
    // Parity check
    //////////////////////////////////////////////////////////////////////

    logic [2:0]         chk_sr;
    logic               par_bad_q;
    logic               par_err_q;

    // Suppressed reads never enter, so conflicts stay unchecked
    // Stage 2 lines up with rd_q
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            chk_sr    <= '0;
            par_bad_q <= 1'b0;
            par_err_q <= 1'b0;
        end
        else
        begin
            chk_sr    <= {chk_sr[1:0], arr_re};
            // XOR tree registered ahead of the output flop
            par_bad_q <= PAR_EN & chk_sr[2] & (^rd_q);
            par_err_q <= par_bad_q;
        end
    end

    // Reporting disable applies straight at the output
    assign par_err = par_err_q & ~par_ctrl.err_dis;

endmodule

`default_nettype wire

/* src/cfg_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ram_cfg.svh"

module cfg_ctrl_regs
(
    input  logic                            clk,
    input  logic                            rst,
    // CPU bus from outside
    input  cfg_ram_pkg::cpu_req_t           cpu_req,
    output cfg_ram_pkg::cpu_rsp_t           cpu_rsp,
    // CPU bus toward the RAM block
    output cfg_ram_pkg::cpu_req_t           ram_req,
    input  cfg_ram_pkg::cpu_rsp_t           ram_rsp,
    // Parity controls and error pulse
    output cfg_ram_pkg::par_ctrl_t          par_ctrl,
    input  logic                            par_err
);

    import cfg_ram_pkg::*;

    localparam int AW = `CFG_ADDR_BITS;
    localparam int DW = `CFG_DATA_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    logic               reg_sel;
    logic               reg_wr;
    logic               reg_rd;
    reg_off_e           reg_off;

    // Top address bit picks the register space
    assign reg_sel = cpu_req.addr[AW];
    assign reg_off = reg_off_e'(cpu_req.addr[AW-1:0]);
    assign reg_wr  = cpu_req.en & cpu_req.ws & reg_sel;
    assign reg_rd  = cpu_req.en & cpu_req.rs & reg_sel;

    // RAM sees the bus unchanged, en only for RAM accesses
    always_comb
    begin
        ram_req    = cpu_req;
        ram_req.en = cpu_req.en & ~reg_sel;
    end

    //////////////////////////////////////////////////////////////////////
    // Control and status
    //////////////////////////////////////////////////////////////////////

    logic               stk_err;

    // Bit 0 force error, bit 1 disable reporting
    always_ff @(posedge clk)
    begin
        if (rst)
            par_ctrl <= '0;
        else if (reg_wr && (reg_off == REG_PAR_CTRL))
        begin
            par_ctrl.force_err <= cpu_req.wdata[0];
            par_ctrl.err_dis   <= cpu_req.wdata[1];
        end
    end

    // Sticky error, write 1 to clear
    // A fresh error in the clear cycle keeps it set
    always_ff @(posedge clk)
    begin
        if (rst)
            stk_err <= 1'b0;
        else if (par_err)
            stk_err <= 1'b1;
        else if (reg_wr && (reg_off == REG_PAR_STAT) && cpu_req.wdata[0])
            stk_err <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Register read and response merge
    //////////////////////////////////////////////////////////////////////

    logic [DW-1:0]      reg_rdata;
    logic [DW-1:0]      reg_rdata_q;
    logic               reg_rdy;

    // Unknown offsets read as zero
    always_comb
    begin
        reg_rdata = '0;
        case (reg_off)
            REG_PAR_CTRL:
            begin
                reg_rdata[0] = par_ctrl.force_err;
                reg_rdata[1] = par_ctrl.err_dis;
            end
            REG_PAR_STAT:
                reg_rdata[0] = stk_err;
            default:
                reg_rdata = '0;
        endcase
    end

    // Register accesses answer one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (rst)
            reg_rdy <= 1'b0;
        else
            reg_rdy <= reg_wr | reg_rd;
    end

    always_ff @(posedge clk)
    begin
        if (reg_rd)
            reg_rdata_q <= reg_rdata;
    end

    // RAM response passes through otherwise
    assign cpu_rsp.rdy   = reg_rdy | ram_rsp.rdy;
    assign cpu_rsp.rdata = !cpu_req.en ? '0 :
                           reg_rdy     ? reg_rdata_q : ram_rsp.rdata;

endmodule

`default_nettype wire

/* src/cfg_table_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ram_cfg.svh"

module cfg_table_top
(
    input  logic                            clk,
    input  logic                            rst,
    // CPU bus
    input  cfg_ram_pkg::cpu_req_t           cpu_req,
    output cfg_ram_pkg::cpu_rsp_t           cpu_rsp,
    // Engine read port
    input  cfg_ram_pkg::eng_req_t           eng_req,
    input  logic                            active,
    output logic [`CFG_DATA_WIDTH-1:0]      eng_rdata
);

    import cfg_ram_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Internal buses
    //////////////////////////////////////////////////////////////////////

    // RAM-space CPU traffic
    cpu_req_t           ram_req;
    cpu_rsp_t           ram_rsp;

    // Parity control and error feedback
    par_ctrl_t          par_ctrl;
    logic               par_err;

    // Decode, control and status registers
    cfg_ctrl_regs u_regs
    (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .ram_req    (ram_req),
        .ram_rsp    (ram_rsp),
        .par_ctrl   (par_ctrl),
        .par_err    (par_err)
    );

    // Parity-protected table
    cfg_ram_par u_ram
    (
        .clk        (clk),
        .rst        (rst),
        .eng_req    (eng_req),
        .active     (active),
        .eng_rdata  (eng_rdata),
        .cpu_req    (ram_req),
        .cpu_rsp    (ram_rsp),
        .par_ctrl   (par_ctrl),
        .par_err    (par_err)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
    output logic clk
);

    // Free-running clock, 4 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

endmodule

`default_nettype wire

/* dv/cfg_ram_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_ram_props
(
    input  logic                            clk,
    input  logic                            rst,
    input  cfg_ram_pkg::cpu_rsp_t           cpu_rsp,
    input  cfg_ram_pkg::par_ctrl_t          par_ctrl,
    input  logic                            par_err,
    input  logic                            arr_re,
    input  cfg_ram_pkg::cpu_rd_state_e      rd_state
);

    import cfg_ram_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Pending read age
    //////////////////////////////////////////////////////////////////////

    logic [6:0]         wait_cnt;

    // Saturating count of cycles spent in RD_WAIT
    always_ff @(posedge clk)
    begin
        if (rst || (rd_state == RD_IDLE))
            wait_cnt <= '0;
        else if (wait_cnt != 7'd127)
            wait_cnt <= wait_cnt + 7'd1;
    end

    //////////////////////////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////////////////////////

    // Ready is a single-cycle pulse
    rdy_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.rdy |=> !cpu_rsp.rdy)
        else $error("rdy held high for two cycles");

    // Error pulse only five cycles after an array read and never while disabled
    err_masked: assert property (@(posedge clk) disable iff (rst)
        par_err |-> (!par_ctrl.err_dis && $past(arr_re, 5)))
        else $error("par_err raised while err_dis is set or without a checked read");

    // Pending CPU read never starves past 64 cycles
    rd_bounded: assert property (@(posedge clk) disable iff (rst)
        wait_cnt < 7'd64)
        else $error("CPU read pending for 64 cycles");

endmodule

`default_nettype wire

/* dv/cfg_ram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ram_cfg.svh"

module cfg_ram_tb;

    import cfg_ram_pkg::*;

    localparam int AW      = `CFG_ADDR_BITS;
    localparam int DW      = `CFG_DATA_WIDTH;
    localparam int DEPTH   = 1 << AW;
    localparam int TIMEOUT = 200;
    localparam int BURST   = 20;

    // Register space addresses
    localparam logic [AW:0] CTRL_ADDR = {1'b1, REG_PAR_CTRL};
    localparam logic [AW:0] STAT_ADDR = {1'b1, REG_PAR_STAT};
    localparam logic [AW:0] UNK_ADDR  = {1'b1, AW'(5)};

    logic               clk;
    logic               rst;
    cpu_req_t           cpu_req;
    cpu_rsp_t           cpu_rsp;
    eng_req_t           eng_req;
    logic               active;
    logic [DW-1:0]      eng_rdata;

    //////////////////////////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////////////////////////

    logic [DW-1:0]      shadow [DEPTH];
    // Stored parity known to be wrong
    logic               bad [DEPTH];
    logic               force_m;
    logic               dis_m;
    logic               sticky_m;

    // Expected CPU responses in issue order
    logic [DW-1:0]      exp_data [$];
    logic               exp_chk [$];
    logic [DW-1:0]      cmp_word;
    logic               cmp_on;

    // Engine expectations for the two-stage read pipe
    logic               eng_new_vld;
    logic [DW-1:0]      eng_new_exp;
    logic               eng_p0_vld;
    logic [DW-1:0]      eng_p0_exp;
    logic               eng_p1_vld;
    logic [DW-1:0]      eng_p1_exp;
    logic [DW-1:0]      eng_hold;

    tb_clk_gen clk_gen_i
    (
        .clk        (clk)
    );

    cfg_table_top dut_i
    (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .eng_req    (eng_req),
        .active     (active),
        .eng_rdata  (eng_rdata)
    );

    bind cfg_ram_par cfg_ram_props props_i
    (
        .clk        (clk),
        .rst        (rst),
        .cpu_rsp    (cpu_rsp),
        .par_ctrl   (par_ctrl),
        .par_err    (par_err),
        .arr_re     (arr_re),
        .rd_state   (rd_state)
    );

    // Expected word for either address space
    function automatic logic [DW-1:0] ref_read(input logic [AW:0] addr);
        logic [DW-1:0] val;
        val = '0;
        if (!addr[AW])
            val = shadow[addr[AW-1:0]];
        else if (addr == CTRL_ADDR)
            val[1:0] = {dis_m, force_m};
        else if (addr == STAT_ADDR)
            val[0] = sticky_m;
        return val;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_val(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus drivers
    //////////////////////////////////////////////////////////////////////

    // Strobe one CPU access and update the model
    task automatic start_access(input logic wr, input logic [AW:0] addr,
                                input logic [DW-1:0] wdata);
        cpu_req.en    = 1'b1;
        cpu_req.ws    = wr;
        cpu_req.rs    = ~wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        exp_data.push_back(ref_read(addr));
        exp_chk.push_back(~wr);
        if (wr && !addr[AW])
        begin
            shadow[addr[AW-1:0]] = wdata;
            bad[addr[AW-1:0]]    = force_m;
        end
        else if (wr && (addr == CTRL_ADDR))
        begin
            force_m = wdata[0];
            dis_m   = wdata[1];
        end
        else if (wr && (addr == STAT_ADDR) && wdata[0])
            sticky_m = 1'b0;
        else if (!wr && !addr[AW] && bad[addr[AW-1:0]] && !dis_m)
            sticky_m = 1'b1;
    endtask

    task automatic wait_rdy(output int cycles);
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            cpu_req.ws = 1'b0;
            cpu_req.rs = 1'b0;
        end
        while (!cpu_rsp.rdy && (cycles < TIMEOUT));
        if (!cpu_rsp.rdy)
            fail_run("timeout waiting for cpu_rsp.rdy");
    endtask

    // Hold en through the rdy cycle and release it after
    task automatic end_access();
        @(negedge clk);
        cpu_req.en = 1'b0;
        cpu_req.ws = 1'b0;
        cpu_req.rs = 1'b0;
    endtask

    task automatic cpu_access(input logic wr, input logic [AW:0] addr,
                              input logic [DW-1:0] wdata);
        int lat;
        @(negedge clk);
        start_access(wr, addr, wdata);
        wait_rdy(lat);
        // With the engine idle RAM reads launch right away
        check_val("cpu_rsp.rdy latency", lat, addr[AW] ? 1 : 5);
        end_access();
    endtask

    task automatic eng_read(input logic [AW-1:0] addr, input logic act);
        @(negedge clk);
        eng_req.re   = 1'b1;
        eng_req.addr = addr;
        active       = act;
        eng_new_vld  = 1'b1;
        // Inactive reads keep the last word
        if (act)
        begin
            eng_hold = ref_read({1'b0, addr});
            if (bad[addr] && !dis_m)
                sticky_m = 1'b1;
        end
        eng_new_exp = eng_hold;
    endtask

    task automatic eng_idle();
        @(negedge clk);
        eng_req.re  = 1'b0;
        active      = 1'b0;
        eng_new_vld = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response comparison
    //////////////////////////////////////////////////////////////////////

    // Engine pipeline advances with the DUT
    always @(posedge clk)
    begin
        eng_p1_vld = eng_p0_vld;
        eng_p1_exp = eng_p0_exp;
        eng_p0_vld = eng_new_vld & ~rst;
        eng_p0_exp = eng_new_exp;
        if (!rst && !cpu_req.en)
            check_val("cpu_rsp.rdata", cpu_rsp.rdata, '0);
    end

    always @(negedge clk)
    begin
        if (!rst && cpu_rsp.rdy)
        begin
            if (exp_data.size() == 0)
                fail_run("rdy pulse with no access outstanding");
            cmp_word = exp_data.pop_front();
            cmp_on   = exp_chk.pop_front();
            if (cmp_on)
                check_val("cpu_rsp.rdata", cpu_rsp.rdata, cmp_word);
        end
        if (!rst && eng_p1_vld)
            check_val("eng_rdata", eng_rdata, eng_p1_exp);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int             lat;
        logic           wr;
        logic [AW-1:0]  a;
        logic [AW-1:0]  b;
        logic [DW-1:0]  d;
        void'($urandom(80));
        rst         = 1'b1;
        cpu_req     = '0;
        eng_req     = '0;
        active      = 1'b0;
        force_m     = 1'b0;
        dis_m       = 1'b0;
        sticky_m    = 1'b0;
        eng_new_vld = 1'b0;
        eng_new_exp = '0;
        eng_p0_vld  = 1'b0;
        eng_p1_vld  = 1'b0;
        eng_hold    = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Fill every entry with clean parity
        for (int i = 0; i < DEPTH; i++)
            cpu_access(1'b1, {1'b0, AW'(i)}, $urandom);
        // Random CPU writes and reads
        for (int i = 0; i < 40; i++)
        begin
            wr = 1'($urandom);
            a  = AW'($urandom);
            d  = $urandom;
            cpu_access(wr, {1'b0, a}, d);
        end

        // Engine reads with one in four inactive
        for (int i = 0; i < 48; i++)
            eng_read(AW'($urandom), (i == 0) || (($urandom % 4) != 0));
        eng_idle();
        eng_idle();

        // CPU read held off by an engine burst elsewhere
        a = AW'($urandom);
        b = a + AW'(1 + ($urandom % (DEPTH - 1)));
        eng_read(b, 1'b1);
        start_access(1'b0, {1'b0, a}, '0);
        for (int i = 0; i < BURST; i++)
        begin
            b = a + AW'(1 + ($urandom % (DEPTH - 1)));
            eng_read(b, 1'b1);
            cpu_req.rs = 1'b0;
            check_val("cpu_rsp.rdy", cpu_rsp.rdy, '0);
        end
        eng_idle();
        check_val("cpu_rsp.rdy", cpu_rsp.rdy, '0);
        wait_rdy(lat);
        check_val("cpu_rsp.rdy latency after burst", lat, 4);
        end_access();
        eng_idle();

        // Planted error sets sticky and a write of 1 clears it
        a = AW'($urandom);
        b = a + AW'(1);
        d = $urandom;
        cpu_access(1'b1, CTRL_ADDR, 32'h1);
        cpu_access(1'b1, {1'b0, a}, d);
        cpu_access(1'b1, CTRL_ADDR, 32'h0);
        cpu_access(1'b0, {1'b0, a}, '0);
        idle_cycles(8);
        cpu_access(1'b0, STAT_ADDR, '0);
        cpu_access(1'b1, STAT_ADDR, 32'h1);
        cpu_access(1'b0, {1'b0, b}, '0);
        idle_cycles(8);
        cpu_access(1'b0, STAT_ADDR, '0);
        cpu_access(1'b1, {1'b0, a}, d);

        // Corrupt word read by CPU and engine with reporting disabled
        cpu_access(1'b1, CTRL_ADDR, 32'h3);
        cpu_access(1'b0, CTRL_ADDR, '0);
        cpu_access(1'b1, {1'b0, a}, d);
        cpu_access(1'b1, CTRL_ADDR, 32'h2);
        cpu_access(1'b0, CTRL_ADDR, '0);
        cpu_access(1'b0, {1'b0, a}, '0);
        for (int i = 0; i < 4; i++)
            eng_read(a, 1'b1);
        eng_idle();
        eng_idle();
        idle_cycles(8);
        cpu_access(1'b0, STAT_ADDR, '0);
        cpu_access(1'b0, UNK_ADDR, '0);
        cpu_access(1'b1, CTRL_ADDR, 32'h0);
        cpu_access(1'b1, {1'b0, a}, d);

        idle_cycles(4);
        if (exp_data.size() != 0)
            fail_run("responses missing at end of run");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/cfg_ram_pkg.sv
src/cfg_sram.sv
src/cfg_ram_par.sv
src/cfg_ctrl_regs.sv
src/cfg_table_top.sv
dv/tb_clk_gen.sv
dv/cfg_ram_props.sv
dv/cfg_ram_tb.sv

/* Makefile */
# Verilator build and run of the config table testbench

VERILATOR ?= verilator
TOP       ?= cfg_ram_tb
SEED      ?= 80
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED)"

# Exit status of the simulation binary is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
